//--- all.f
+incdir+common
common/cumulPkg.sv
src/sampleWindow.sv
src/fillTracker.sv
channel/fixLutUnit.sv
channel/fixRecursion.sv
channel/cFixMult.sv
channel/channelPath.sv
src/cumulFixedTop.sv
tb/cumul_props.sv
tb/cumulTb.sv

//--- run.sh
#!/bin/sh
# Build with Verilator, run, and decide on the log contents
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal -f all.f --top-module cumulTb -o cumulSim \
    && ./obj_dir/cumulSim > sim.log 2>&1 \
    || echo "Build or simulation did not complete"
if [ -f sim.log ]; then
    cat sim.log
fi
grep -q "^Finished with no errors$" sim.log \
    && echo "RESULT: PASS" \
    || { echo "RESULT: FAIL"; exit 1; }

//--- tb/cumulTb.sv
`timescale 1ns/10ps
`default_nettype none

`include "cumul_consts.svh"
`include "cumul_coeffs.svh"

module cumulTb;

    localparam int tabLen = 64;
    localparam int segB = 40;
    localparam int rstCycles = 16;
    // Edges from sampling a vector to its result on out
    localparam int pipeDepth = 4;
    localparam int fixW = `N_TOT + 1;
    localparam int cycleLimit = tabLen + 2 * (rstCycles + pipeDepth + 1) + 40;
    localparam cumulPkg::outT outZero = {1'b1, {(`OUT_WIDTH - 1){1'b0}}};
    localparam longint fixMax = (64'sd1 <<< `N_TOT) - 1;
    localparam longint fixMin = -(64'sd1 <<< `N_TOT);

    typedef cumulPkg::fixT [`NUM_CTRL-1:0] perChT;

    typedef struct {
        cumulPkg::ctrlT ctrl;
        cumulPkg::outT  outExp;
        logic           validExp;
    } rowT;

    // Ahead add R/I, ahead sub R/I, lookback R/I
    localparam cumulPkg::factTabT lutTab [6] = '{
        `LA_ADD_R, `LA_ADD_I, `LA_SUB_R, `LA_SUB_I, `LB_R, `LB_I
    };
    // Poles ahead R/I and back R/I, then weights fwd R/I and back R/I
    localparam perChT coef [8] = '{
        `LA_FACT_R, `LA_FACT_I, `LB_FACT_R, `LB_FACT_I,
        `W_FWD_R, `W_FWD_I, `W_BACK_R, `W_BACK_I
    };

    logic           clkDS;
    logic           rst;
    cumulPkg::ctrlT ctrl;
    cumulPkg::outT  out;
    logic           valid;

    rowT tab [tabLen];
    int  seed;
    int  errCount;
    int  checkCount;
    int  cycleCount = 0;

    cumulFixedTop u_cumulFixedTop (
        .clkDS(clkDS), .rst(rst), .ctrl(ctrl),
        .out(out), .valid(valid)
    );

    initial begin
        clkDS = 1'b0;
        forever #2 clkDS = ~clkDS;
    end

    always @(posedge clkDS) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= cycleLimit) begin
            $display("Timeout: run still going after %0d cycles", cycleLimit);
            $display("Finished with errors");
            $finish;
        end
    end

    function automatic longint wrapFix(input longint v);
        logic signed [fixW-1:0] w;
        w = v[fixW-1:0];
        return w;
    endfunction

    function automatic longint lutSum(input cumulPkg::ctrlT sel, input cumulPkg::factVecT facts);
        longint s;
        s = 0;
        for (int i = 0; i < `NUM_CTRL; i++) begin
            s = sel[i] ? s + longint'(facts[i]) : s - longint'(facts[i]);
        end
        return wrapFix(s);
    endfunction

    function automatic cumulPkg::ctrlT reverseBits(input cumulPkg::ctrlT v);
        cumulPkg::ctrlT r;
        for (int b = 0; b < `NUM_CTRL; b++) begin
            r[b] = v[`NUM_CTRL-1-b];
        end
        return r;
    endfunction

    task automatic checkValue(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
        checkCount++;
        if (got !== exp) begin
            errCount++;
            $display("** Error at %0d ns: %s is %0h, expected %0h", $time, name, got, exp);
        end
    endtask

    task automatic fillTable;
        int rnd;
        for (int i = 0; i < tabLen; i++) begin
            if (i < 16) begin
                tab[i].ctrl = cumulPkg::ctrlT'(3);
            end else if (i < 24) begin
                tab[i].ctrl = (i % 2 == 1) ? cumulPkg::ctrlT'(2) : cumulPkg::ctrlT'(1);
            end else if (i < 28) begin
                tab[i].ctrl = (i % 2 == 1) ? cumulPkg::ctrlT'(3) : cumulPkg::ctrlT'(0);
            end else begin
                rnd = $random(seed);
                tab[i].ctrl = rnd[`NUM_CTRL-1:0];
            end
        end
    endtask

    // Cycle model of one run from reset, fills the expected columns
    task automatic buildExpected(input int first, input int len);
        cumulPkg::ctrlT win [`DEPTH+1];
        cumulPkg::ctrlT aTap;
        longint         lut [`NUM_CTRL][6];
        longint         st [`NUM_CTRL][4];
        longint         mul [`NUM_CTRL][2];
        longint         uR [2];
        longint         uI [2];
        longint         acc;
        longint         tR;
        logic [63:0]    bitsV;
        cumulPkg::outT  outM;
        int             cnt;
        int             s;
        int             w;
        logic           aEn;
        logic           bEn;
        logic           vld;
        for (int j = 0; j <= `DEPTH; j++) win[j] = '0;
        for (int ch = 0; ch < `NUM_CTRL; ch++) begin
            for (int k = 0; k < 6; k++) lut[ch][k] = lutSum('0, lutTab[k][ch]);
            for (int k = 0; k < 4; k++) st[ch][k] = 0;
            mul[ch][0] = 0;
            mul[ch][1] = 0;
        end
        outM = outZero;
        cnt = 0;
        aEn = 1'b0;
        bEn = 1'b0;
        vld = 1'b0;
        for (int e = 1; e <= len + pipeDepth; e++) begin
            // Output first, so every stage reads last cycle's values
            acc = 0;
            for (int ch = 0; ch < `NUM_CTRL; ch++) acc = acc + mul[ch][0] + mul[ch][1];
            acc = (acc > fixMax) ? fixMax : ((acc < fixMin) ? fixMin : acc);
            bitsV = acc >>> (`N_MANT + 1 - `OUT_WIDTH);
            outM = {~bitsV[`OUT_WIDTH-1], bitsV[`OUT_WIDTH-2:0]};
            for (int ch = 0; ch < `NUM_CTRL; ch++) begin
                // fwd weight on lookback state, back weight on lookahead state
                for (int m = 0; m < 2; m++) begin
                    s = 2 - 2 * m;
                    w = 4 + 2 * m;
                    mul[ch][m] = wrapFix((st[ch][s] * coef[w][ch]
                                          - st[ch][s+1] * coef[w+1][ch]) >>> `N_MANT);
                end
                uR[0] = (aEn ? lut[ch][0] : 0) - (bEn ? lut[ch][2] : 0);
                uI[0] = (aEn ? lut[ch][1] : 0) - (bEn ? lut[ch][3] : 0);
                uR[1] = bEn ? lut[ch][4] : 0;
                uI[1] = bEn ? lut[ch][5] : 0;
                for (int r = 0; r < 2; r++) begin
                    tR = wrapFix(((coef[2*r][ch] * st[ch][2*r] - coef[2*r+1][ch]
                                   * st[ch][2*r+1]) >>> `N_MANT) + uR[r]);
                    st[ch][2*r+1] = wrapFix(((coef[2*r][ch] * st[ch][2*r+1]
                                   + coef[2*r+1][ch] * st[ch][2*r]) >>> `N_MANT) + uI[r]);
                    st[ch][2*r] = tR;
                end
            end
            aTap = reverseBits(win[0]);
            for (int ch = 0; ch < `NUM_CTRL; ch++) begin
                for (int k = 0; k < 6; k++) begin
                    lut[ch][k] = lutSum((k < 2) ? aTap : win[`DEPTH], lutTab[k][ch]);
                end
            end
            for (int j = `DEPTH; j > 0; j--) win[j] = win[j-1];
            win[0] = (e <= len) ? tab[first+e-1].ctrl : '0;
            if (!vld) begin
                if (cnt == `DEPTH + 1) bEn = 1'b1;
                if (cnt == `DEPTH + 4) vld = 1'b1;
                cnt++;
            end
            aEn = 1'b1;
            if (e > pipeDepth) begin
                tab[first+e-pipeDepth-1].outExp = outM;
                tab[first+e-pipeDepth-1].validExp = vld;
            end
        end
    endtask

    task automatic resetDut;
        rst = 1'b0;
        repeat (rstCycles) begin
            @(posedge clkDS);
            #1;
            checkValue("out", 32'(out), 32'(outZero));
            checkValue("valid", 32'(valid), 32'h0);
        end
        rst = 1'b1;
    endtask

    task automatic applySegment(input int first, input int len);
        for (int c = 0; c <= len + pipeDepth; c++) begin
            if (c > pipeDepth) begin
                checkValue("out", 32'(out), 32'(tab[first+c-pipeDepth-1].outExp));
                checkValue("valid", 32'(valid), 32'(tab[first+c-pipeDepth-1].validExp));
            end
            ctrl = (c < len) ? tab[first+c].ctrl : '0;
            @(posedge clkDS);
            #1;
        end
    endtask

    initial begin
        rst = 1'b0;
        ctrl = '0;
        errCount = 0;
        checkCount = 0;
        seed = 32'h3efd_aa52;
        fillTable();
        buildExpected(0, segB);
        buildExpected(segB, tabLen - segB);
        resetDut();
        applySegment(0, segB);
        // Reset in mid-run, model restarts from zero state
        resetDut();
        applySegment(segB, tabLen - segB);
        $display("Closing: %0d errors in %0d checks", errCount, checkCount);
        if (errCount == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- tb/cumul_props.sv
`timescale 1ns/10ps
`default_nettype none

module cumul_props (
    input logic                clkDS,
    input logic                rst,
    input logic                valid,
    input logic                backEn,
    input cumulPkg::fillStateE state
);

    // Valid is a level that only reset clears
    validHolds: assert property (@(posedge clkDS) disable iff (!rst) valid |=> valid)
        else $error("valid dropped while out of reset");

    backEnWithValid: assert property (@(posedge clkDS) disable iff (!rst) valid |-> backEn)
        else $error("valid high while the lookback path is closed");

    runMatchesValid: assert property (
        @(posedge clkDS) disable iff (!rst) (state == cumulPkg::stRun) == valid
    ) else $error("fill state and valid disagree");

endmodule

bind cumulFixedTop cumul_props u_cumulProps (
    .clkDS(clkDS), .rst(rst), .valid(valid),
    .backEn(backEn), .state(u_fillTracker.state)
);

`default_nettype wire

//--- src/cumulFixedTop.sv
`timescale 1ns/10ps
`default_nettype none

`include "cumul_consts.svh"

module cumulFixedTop (
    input  logic           clkDS,
    input  logic           rst,
    input  cumulPkg::ctrlT ctrl,
    output cumulPkg::outT  out,
    output logic           valid
);

    localparam int sumW = `N_TOT + 1 + $clog2(2 * `NUM_CTRL);

    // Limits of the internal word, sign-extended to the sum width
    localparam logic signed [sumW-1:0] satHi = {{(sumW - `N_TOT){1'b0}}, {`N_TOT{1'b1}}};
    localparam logic signed [sumW-1:0] satLo = ~satHi;

    cumulPkg::ctrlT aheadTap;
    cumulPkg::ctrlT oldTap;
    logic           aheadEn;
    logic           backEn;

    cumulPkg::fixT           fwdOut [`NUM_CTRL];
    cumulPkg::fixT           backOut [`NUM_CTRL];
    logic signed [sumW-1:0]  acc;
    cumulPkg::fixT           satSum;
    logic [`OUT_WIDTH-1:0]   scaled;

    sampleWindow u_sampleWindow (
        .clkDS(clkDS), .rst(rst), .ctrl(ctrl),
        .aheadTap(aheadTap), .oldTap(oldTap)
    );

    fillTracker u_fillTracker (
        .clkDS(clkDS), .rst(rst),
        .aheadEn(aheadEn), .backEn(backEn), .valid(valid)
    );

    for (genvar ch = 0; ch < `NUM_CTRL; ch++) begin : gChannel
        channelPath #(.CH(ch)) u_channelPath (
            .clkDS(clkDS), .rst(rst),
            .aheadTap(aheadTap), .oldTap(oldTap),
            .aheadEn(aheadEn), .backEn(backEn),
            .fwdOut(fwdOut[ch]), .backOut(backOut[ch])
        );
    end

    always_comb begin
        acc = '0;
        for (int i = 0; i < `NUM_CTRL; i++) begin
            acc = acc + sumW'(fwdOut[i]) + sumW'(backOut[i]);
        end
        if (acc > satHi) begin
            satSum = satHi[`N_TOT:0];
        end else if (acc < satLo) begin
            satSum = satLo[`N_TOT:0];
        end else begin
            satSum = acc[`N_TOT:0];
        end
        // Sign and top fraction bits give a Q0.13 sample
        scaled = satSum[`N_MANT -: `OUT_WIDTH];
    end

    always_ff @(posedge clkDS) begin
        if (!rst) begin
            out <= {1'b1, {(`OUT_WIDTH - 1){1'b0}}};
        end else begin
            out <= {~scaled[`OUT_WIDTH-1], scaled[`OUT_WIDTH-2:0]};
        end
    end

endmodule

`default_nettype wire

//--- channel/channelPath.sv
`timescale 1ns/10ps
`default_nettype none

`include "cumul_consts.svh"
`include "cumul_coeffs.svh"

module channelPath #(
    parameter int CH = 0
) (
    input  logic           clkDS,
    input  logic           rst,
    input  cumulPkg::ctrlT aheadTap,
    input  cumulPkg::ctrlT oldTap,
    input  logic           aheadEn,
    input  logic           backEn,
    output cumulPkg::fixT  fwdOut,
    output cumulPkg::fixT  backOut
);

    localparam cumulPkg::factTabT laAddR = `LA_ADD_R;
    localparam cumulPkg::factTabT laAddI = `LA_ADD_I;
    localparam cumulPkg::factTabT laSubR = `LA_SUB_R;
    localparam cumulPkg::factTabT laSubI = `LA_SUB_I;
    localparam cumulPkg::factTabT lbR    = `LB_R;
    localparam cumulPkg::factTabT lbI    = `LB_I;

    localparam cumulPkg::fixT [`NUM_CTRL-1:0] laFactR = `LA_FACT_R;
    localparam cumulPkg::fixT [`NUM_CTRL-1:0] laFactI = `LA_FACT_I;
    localparam cumulPkg::fixT [`NUM_CTRL-1:0] lbFactR = `LB_FACT_R;
    localparam cumulPkg::fixT [`NUM_CTRL-1:0] lbFactI = `LB_FACT_I;
    localparam cumulPkg::fixT [`NUM_CTRL-1:0] wFwdR   = `W_FWD_R;
    localparam cumulPkg::fixT [`NUM_CTRL-1:0] wFwdI   = `W_FWD_I;
    localparam cumulPkg::fixT [`NUM_CTRL-1:0] wBackR  = `W_BACK_R;
    localparam cumulPkg::fixT [`NUM_CTRL-1:0] wBackI  = `W_BACK_I;

    cumulPkg::fixT addR, addI, subR, subI, lbSumR, lbSumI;
    cumulPkg::fixT aheadInR, aheadInI, backInR, backInI;
    cumulPkg::fixT aheadStR, aheadStI, backStR, backStI;

    fixLutUnit u_laAddR (.clkDS(clkDS), .sel(aheadTap), .facts(laAddR[CH]), .result(addR));
    fixLutUnit u_laAddI (.clkDS(clkDS), .sel(aheadTap), .facts(laAddI[CH]), .result(addI));
    fixLutUnit u_laSubR (.clkDS(clkDS), .sel(oldTap), .facts(laSubR[CH]), .result(subR));
    fixLutUnit u_laSubI (.clkDS(clkDS), .sel(oldTap), .facts(laSubI[CH]), .result(subI));
    fixLutUnit u_lbR (.clkDS(clkDS), .sel(oldTap), .facts(lbR[CH]), .result(lbSumR));
    fixLutUnit u_lbI (.clkDS(clkDS), .sel(oldTap), .facts(lbI[CH]), .result(lbSumI));

    // Terms stay out until their taps hold real data
    always_comb begin
        aheadInR = (aheadEn ? addR : '0) - (backEn ? subR : '0);
        aheadInI = (aheadEn ? addI : '0) - (backEn ? subI : '0);
        backInR  = backEn ? lbSumR : '0;
        backInI  = backEn ? lbSumI : '0;
    end

    // Backward-time recursion
    fixRecursion u_aheadRec (
        .clkDS(clkDS), .rst(rst),
        .inR(aheadInR), .inI(aheadInI),
        .factR(laFactR[CH]), .factI(laFactI[CH]),
        .outR(aheadStR), .outI(aheadStI)
    );

    // Forward-time recursion
    fixRecursion u_backRec (
        .clkDS(clkDS), .rst(rst),
        .inR(backInR), .inI(backInI),
        .factR(lbFactR[CH]), .factI(lbFactI[CH]),
        .outR(backStR), .outI(backStI)
    );

    // Only real parts leave the channel
    cFixMult u_fwdWeight (
        .clkDS(clkDS),
        .aR(backStR), .aI(backStI),
        .bR(wFwdR[CH]), .bI(wFwdI[CH]),
        .resR(fwdOut), .resI()
    );

    cFixMult u_backWeight (
        .clkDS(clkDS),
        .aR(aheadStR), .aI(aheadStI),
        .bR(wBackR[CH]), .bI(wBackI[CH]),
        .resR(backOut), .resI()
    );

endmodule

`default_nettype wire

//--- channel/cFixMult.sv
`timescale 1ns/10ps
`default_nettype none

`include "cumul_consts.svh"

module cFixMult (
    input  logic          clkDS,
    input  cumulPkg::fixT aR,
    input  cumulPkg::fixT aI,
    input  cumulPkg::fixT bR,
    input  cumulPkg::fixT bI,
    output cumulPkg::fixT resR,
    output cumulPkg::fixT resI
);

    localparam int prodW = 2 * (`N_TOT + 1);

    logic signed [prodW-1:0] prodR;
    logic signed [prodW-1:0] prodI;
    logic signed [prodW-1:0] shR;
    logic signed [prodW-1:0] shI;

    always_comb begin
        prodR = aR * bR - aI * bI;
        prodI = aI * bR + aR * bI;
        shR   = prodR >>> `N_MANT;
        shI   = prodI >>> `N_MANT;
    end

    // Truncated to the internal word
    always_ff @(posedge clkDS) begin
        resR <= shR[`N_TOT:0];
        resI <= shI[`N_TOT:0];
    end

endmodule

`default_nettype wire

//--- channel/fixRecursion.sv
`timescale 1ns/10ps
`default_nettype none

`include "cumul_consts.svh"

module fixRecursion (
    input  logic          clkDS,
    input  logic          rst,
    input  cumulPkg::fixT inR,
    input  cumulPkg::fixT inI,
    input  cumulPkg::fixT factR,
    input  cumulPkg::fixT factI,
    output cumulPkg::fixT outR,
    output cumulPkg::fixT outI
);

    localparam int prodW = 2 * (`N_TOT + 1);

    logic signed [prodW-1:0] prodR;
    logic signed [prodW-1:0] prodI;
    logic signed [prodW-1:0] shR;
    logic signed [prodW-1:0] shI;
    cumulPkg::fixT           truncR;
    cumulPkg::fixT           truncI;

    // factor * state, back to N_MANT fraction bits
    always_comb begin
        prodR  = factR * outR - factI * outI;
        prodI  = factR * outI + factI * outR;
        shR    = prodR >>> `N_MANT;
        shI    = prodI >>> `N_MANT;
        truncR = shR[`N_TOT:0];
        truncI = shI[`N_TOT:0];
    end

    always_ff @(posedge clkDS) begin
        if (!rst) begin
            outR <= '0;
            outI <= '0;
        end else begin
            outR <= truncR + inR;
            outI <= truncI + inI;
        end
    end

endmodule

`default_nettype wire

//--- channel/fixLutUnit.sv
`timescale 1ns/10ps
`default_nettype none

`include "cumul_consts.svh"

module fixLutUnit (
    input  logic              clkDS,
    input  cumulPkg::ctrlT    sel,
    input  cumulPkg::factVecT facts,
    output cumulPkg::fixT     result
);

    cumulPkg::fixT sum;

    function automatic cumulPkg::fixT signedTerm(
        input logic          bitSel,
        input cumulPkg::fixT fact
    );
        cumulPkg::lutSignE rule;
        rule = cumulPkg::lutSignE'(bitSel);
        case (rule)
            cumulPkg::signAdd: signedTerm = fact;
            default:           signedTerm = -fact;
        endcase
    endfunction

    // Every bit contributes, either +fact or -fact
    always_comb begin
        sum = '0;
        for (int i = 0; i < `NUM_CTRL; i++) begin
            sum = sum + signedTerm(sel[i], facts[i]);
        end
    end

    always_ff @(posedge clkDS) begin
        result <= sum;
    end

endmodule

`default_nettype wire

//--- src/fillTracker.sv
`timescale 1ns/10ps
`default_nettype none

`include "cumul_consts.svh"

module fillTracker (
    input  logic clkDS,
    input  logic rst,
    output logic aheadEn,
    output logic backEn,
    output logic valid
);

    localparam int cntW = $clog2(`DEPTH + 5);

    cumulPkg::fillStateE state;
    logic [cntW-1:0]     count;

    always_ff @(posedge clkDS) begin
        if (!rst) begin
            state   <= cumulPkg::stFill;
            count   <= '0;
            aheadEn <= 1'b0;
            backEn  <= 1'b0;
            valid   <= 1'b0;
        end else begin
            aheadEn <= 1'b1;
            case (state)
                cumulPkg::stFill: begin
                    count <= count + 1'b1;
                    // Old tap holds real data, open lookback path
                    if (count == cntW'(`DEPTH + 1)) begin
                        backEn <= 1'b1;
                    end
                    // First full result reaches out on this edge
                    if (count == cntW'(`DEPTH + 4)) begin
                        valid <= 1'b1;
                        state <= cumulPkg::stRun;
                    end
                end
                default: begin
                    backEn <= 1'b1;
                    valid  <= 1'b1;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

//--- src/sampleWindow.sv
`timescale 1ns/10ps
`default_nettype none

`include "cumul_consts.svh"

module sampleWindow (
    input  logic           clkDS,
    input  logic           rst,
    input  cumulPkg::ctrlT ctrl,
    output cumulPkg::ctrlT aheadTap,
    output cumulPkg::ctrlT oldTap
);

    // Entry 0 is the newest vector
    cumulPkg::ctrlT [`DEPTH:0] window;

    always_ff @(posedge clkDS) begin
        if (!rst) begin
            window <= '0;
        end else begin
            window <= {window[`DEPTH-1:0], ctrl};
        end
    end

    // Backward-time tables see the newest vector bit-reversed
    always_comb begin
        for (int b = 0; b < `NUM_CTRL; b++) begin
            aheadTap[b] = window[0][`NUM_CTRL-1-b];
        end
    end

    assign oldTap = window[`DEPTH];

endmodule

`default_nettype wire

//--- common/cumulPkg.sv
`default_nettype none

`include "cumul_consts.svh"

package cumulPkg;

    // Signed internal word, N_INT integer and N_MANT fraction bits
    typedef logic signed [`N_TOT:0] fixT;

    typedef logic [`OUT_WIDTH-1:0] outT;

    // One vector of control decisions
    typedef logic [`NUM_CTRL-1:0] ctrlT;

    // One factor per control bit
    typedef fixT [`NUM_CTRL-1:0] factVecT;

    // Factor vectors for all channels
    typedef factVecT [`NUM_CTRL-1:0] factTabT;

    typedef enum logic {
        stFill = 1'b0,
        stRun  = 1'b1
    } fillStateE;

    // Set bit adds its factor, clear bit subtracts it
    typedef enum logic {
        signSub = 1'b0,
        signAdd = 1'b1
    } lutSignE;

endpackage

`default_nettype wire

//--- common/cumul_consts.svh
`ifndef CUMUL_CONSTS_SVH
`define CUMUL_CONSTS_SVH

// Control decisions per sample, also the channel count
`define NUM_CTRL 2

// Window depth in samples
`define DEPTH 4

// Internal fixed-point word
`define N_INT 9
`define N_MANT 14

// Sign bit sits above N_TOT, so the word is N_TOT+1 wide
`define N_TOT (`N_INT + `N_MANT)

// Offset-binary output sample
`define OUT_WIDTH 14

`endif

//--- common/cumul_coeffs.svh
`ifndef CUMUL_COEFFS_SVH
`define CUMUL_COEFFS_SVH

// Integer factor in the internal word, scaled by 2**N_MANT
`define FIX(v) cumulPkg::fixT'(v)

// LUT factors per channel, ordered {bit1, bit0}
`define LA_ADD_R_0 {`FIX(-318), `FIX(742)}
`define LA_ADD_I_0 {`FIX(205), `FIX(-96)}
`define LA_SUB_R_0 {`FIX(-121), `FIX(287)}
`define LA_SUB_I_0 {`FIX(140), `FIX(-33)}
`define LB_R_0 {`FIX(655), `FIX(-274)}
`define LB_I_0 {`FIX(-88), `FIX(190)}

`define LA_ADD_R_1 {`FIX(510), `FIX(-236)}
`define LA_ADD_I_1 {`FIX(-172), `FIX(308)}
`define LA_SUB_R_1 {`FIX(198), `FIX(-95)}
`define LA_SUB_I_1 {`FIX(-61), `FIX(122)}
`define LB_R_1 {`FIX(-403), `FIX(587)}
`define LB_I_1 {`FIX(251), `FIX(-47)}

// Tables indexed by channel
`define LA_ADD_R {`LA_ADD_R_1, `LA_ADD_R_0}
`define LA_ADD_I {`LA_ADD_I_1, `LA_ADD_I_0}
`define LA_SUB_R {`LA_SUB_R_1, `LA_SUB_R_0}
`define LA_SUB_I {`LA_SUB_I_1, `LA_SUB_I_0}
`define LB_R {`LB_R_1, `LB_R_0}
`define LB_I {`LB_I_1, `LB_I_0}

// Recursion poles, {ch1, ch0}, all inside the unit circle
`define LA_FACT_R {`FIX(13420), `FIX(14011)}
`define LA_FACT_I {`FIX(-5187), `FIX(3562)}
`define LB_FACT_R {`FIX(14390), `FIX(13905)}
`define LB_FACT_I {`FIX(2874), `FIX(-4480)}

// Output weights, {ch1, ch0}
`define W_FWD_R {`FIX(1180), `FIX(1342)}
`define W_FWD_I {`FIX(-417), `FIX(265)}
`define W_BACK_R {`FIX(1096), `FIX(1253)}
`define W_BACK_I {`FIX(388), `FIX(-302)}

`endif
